/* Bender.yml */
package:
  name: fetch_unit

sources:
  - hw/riscv_isa_pkg.sv
  - hw/fetch_pkg.sv
  - hw/icache_refill.sv
  - hw/icache_l1i.sv
  - hw/fetch_pc_ctrl.sv
  - hw/fetch_top.sv
  - target: simulation
    files:
      - dv/fetch_checker.sv
      - dv/tb_fetch.sv

/* dv/fetch_checker.sv */
`timescale 1ns/1ps

module fetch_checker
  import riscv_isa_pkg::*;
  import fetch_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input logic       valid_o,
  input logic       ready_i,
  input fetch_pkt_t pkt_o,
  input mem_req_t   mem_req_o,
  input mem_rsp_t   mem_rsp_i,
  input spec_t      spec_o
);

  // one word read in flight at most
  logic outstanding_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding_q <= 1'b0;
    end else if (mem_rsp_i.valid) begin
      outstanding_q <= 1'b0;
    end else if (mem_req_o.valid) begin
      outstanding_q <= 1'b1;
    end
  end

  // a bad pulse may drop valid, the packet itself must not move
  a_pkt_stable: assert property (@(posedge clk) disable iff (rst)
    (valid_o && !ready_i) |=> (!valid_o || $stable(pkt_o)))
    else $error("pkt_o changed while waiting for ready");

  a_req_strobe: assert property (@(posedge clk) disable iff (rst)
    mem_req_o.valid |=> !mem_req_o.valid)
    else $error("mem_req_o.valid held for two cycles");

  a_req_in_order: assert property (@(posedge clk) disable iff (rst)
    mem_req_o.valid |-> !outstanding_q)
    else $error("request issued before previous response");

  a_good_bad: assert property (@(posedge clk) disable iff (rst)
    !(spec_o.good && spec_o.bad))
    else $error("good and bad speculation pulsed together");

endmodule

bind fetch_top fetch_checker u_checker (.*);

/* dv/tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch
  import riscv_isa_pkg::*;
  import fetch_pkg::*;
();

  localparam int num_pkts = 40;
  localparam int timeout_cycles = 40 * num_pkts;
  localparam int mem_words = 64;

  logic       clk;
  logic       rst;
  logic       ready_i;
  logic       valid_o;
  mem_req_t   mem_req_o;
  mem_rsp_t   mem_rsp_i;
  commit_t    commit_i;
  fetch_pkt_t pkt_o;
  spec_t      spec_o;

  int          seed = 32'h94ef_6a65;
  logic [31:0] mem [mem_words];
  logic [31:0] rsp_addr;
  int          rsp_cnt;
  logic [31:0] expected_pc;
  fetch_pkt_t  spec_list[$];
  fetch_pkt_t  be_q[$];
  int          be_cnt;
  int          cycles;
  int          arch_count;
  int          good_count;
  int          bad_count;
  int          fence_count;
  logic        btb_v;
  logic        load_pending;
  logic        branch_pending;
  logic        fence_pending;
  logic        fence_wait;
  logic [num_lines-1:0] shadow_v;
  logic [tag_w-1:0]     shadow_tag [num_lines];

  fetch_top UUT (
    .clk       (clk),
    .rst       (rst),
    .mem_req_o (mem_req_o),
    .mem_rsp_i (mem_rsp_i),
    .commit_i  (commit_i),
    .ready_i   (ready_i),
    .valid_o   (valid_o),
    .pkt_o     (pkt_o),
    .spec_o    (spec_o)
  );

  always #10 clk = ~clk;

  initial begin
    logic [31:0] a;
    clk       = 1'b0;
    rst       = 1'b1;
    ready_i   = 1'b0;
    commit_i  = '0;
    mem_rsp_i = '0;
    // unused words are op-imm with address-dependent fields
    for (int i = 0; i < mem_words; i++) begin
      a = i;
      mem[i] = {a[24:0], 7'h13};
    end
    mem[0]  = 32'h0010_0093;
    mem[1]  = 32'h0000_2103;
    mem[2]  = inst_fence_i;
    mem[3]  = 32'h0010_0093;
    mem[4]  = 32'h0100_006f;
    mem[8]  = 32'h0010_0093;
    mem[9]  = 32'h0000_0663;
    // loop body, store first so it lands in the prediction window
    mem[12] = 32'h0010_2023;
    mem[13] = 32'h0010_0093;
    mem[14] = 32'h0010_0093;
    mem[15] = 32'hff5f_f06f;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

  function automatic logic is_taken(input logic [31:0] pc);
    return pc == 32'h0000_0024;
  endfunction

  function automatic logic is_branch_class(input logic [31:0] inst);
    return inst[6:0] == op_jal || inst[6:0] == op_jalr || inst[6:0] == op_branch ||
           inst[6:0] == op_system;
  endfunction

  function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] inst);
    logic [31:0] j_imm;
    logic [31:0] b_imm;
    j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    if (inst[6:0] == op_jal) begin
      return pc + j_imm;
    end else if (inst[6:0] == op_branch) begin
      return is_taken(pc) ? pc + b_imm : pc + 32'd4;
    end else if (inst[6:0] == op_jalr) begin
      // every jalr in the image returns to the start address
      return pc_reset;
    end
    return pc + 32'd4;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic fail_plain(input string msg);
    $display("%0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic accept_pkt();
    check_eq(pkt_o.inst, mem[pkt_o.pc[7:2]], "packet word");
    if (load_pending || branch_pending || fence_pending) begin
      fail_plain("a packet was issued while fetch should be stalled");
    end
    if (fence_wait) begin
      fail_plain("fetch after fence.i hit without any refill");
    end
    if (spec_o.active) begin
      if (pkt_o.inst[6:0] == op_load || pkt_o.inst[6:0] == op_store) begin
        fail_plain("a load or store was issued during an open prediction");
      end
      spec_list.push_back(pkt_o);
    end else begin
      check_eq(pkt_o.pc, expected_pc, "packet pc");
      expected_pc = next_pc(pkt_o.pc, pkt_o.inst);
      arch_count++;
    end
    if (is_branch_class(pkt_o.inst) && !(btb_v && !spec_o.active)) begin
      branch_pending = 1'b1;
    end
    if (pkt_o.inst[6:0] == op_load) begin
      load_pending = 1'b1;
    end
    if (pkt_o.inst == inst_fence_i) begin
      fence_pending = 1'b1;
      fence_wait    = 1'b1;
      shadow_v      = '0;
      fence_count++;
    end
    be_q.push_back(pkt_o);
  endtask

  task automatic issue_commit(input fetch_pkt_t e);
    commit_t     c;
    logic [31:0] np;
    c  = '0;
    np = next_pc(e.pc, e.inst);
    if (is_branch_class(e.inst) && np != e.pc + 32'd4) begin
      c.redirect        = 1'b1;
      c.redirect_target = np;
      btb_v             = 1'b1;
    end else begin
      c.retire    = 1'b1;
      c.retire_pc = e.pc;
    end
    if (e.inst[6:0] == op_load) begin
      c.load_retire = 1'b1;
      load_pending  = 1'b0;
    end
    if (is_branch_class(e.inst)) begin
      branch_pending = 1'b0;
    end
    if (e.inst == inst_fence_i) begin
      fence_pending = 1'b0;
    end
    commit_i <= c;
  endtask

  // memory, one response per request after 1 to 4 cycles
  task automatic serve_memory();
    mem_rsp_i <= '0;
    if (rst) begin
      rsp_cnt = 0;
    end else begin
      if (mem_req_o.valid) begin
        rsp_addr = mem_req_o.addr;
        rsp_cnt  = 1 + ($unsigned($random(seed)) % 4);
      end
      if (rsp_cnt > 0) begin
        rsp_cnt--;
        if (rsp_cnt == 0) begin
          mem_rsp_i <= '{data: mem[rsp_addr[7:2]], valid: 1'b1};
        end
      end
    end
  endtask

  // back-end model and comparison
  always @(posedge clk) begin
    serve_memory();
    commit_i <= '0;
    ready_i  <= ($random(seed) & 3) != 0;
    if (rst) begin
      expected_pc    = pc_reset;
      be_cnt         = 0;
      cycles         = 0;
      arch_count     = 0;
      good_count     = 0;
      bad_count      = 0;
      fence_count    = 0;
      btb_v          = 1'b0;
      load_pending   = 1'b0;
      branch_pending = 1'b0;
      fence_pending  = 1'b0;
      fence_wait     = 1'b0;
      shadow_v       = '0;
    end else begin
      cycles++;
      if (cycles > timeout_cycles) begin
        fail_plain("timeout, fetch stopped delivering packets");
      end
      if (mem_req_o.valid) begin
        fence_wait = 1'b0;
        if (mem_req_o.addr[2] == 1'b0) begin
          if (shadow_v[mem_req_o.addr[4:3]] && shadow_tag[mem_req_o.addr[4:3]] ==
              mem_req_o.addr[31:5]) begin
            fail_plain("refill requested for a line that is still cached");
          end
          shadow_v[mem_req_o.addr[4:3]]   = 1'b1;
          shadow_tag[mem_req_o.addr[4:3]] = mem_req_o.addr[31:5];
        end
      end
      if (spec_o.good) begin
        good_count++;
        foreach (spec_list[i]) begin
          check_eq(spec_list[i].pc, expected_pc, "predicted pc");
          expected_pc = next_pc(spec_list[i].pc, spec_list[i].inst);
          arch_count++;
        end
        spec_list.delete();
      end
      if (spec_o.bad) begin
        bad_count++;
        spec_list.delete();
        be_q.delete();
        branch_pending = 1'b0;
      end
      if (valid_o && ready_i) begin
        accept_pkt();
      end
      if (be_cnt > 0) begin
        be_cnt--;
      end else if (be_q.size() > 0) begin
        issue_commit(be_q.pop_front());
        be_cnt = 2 + ($unsigned($random(seed)) % 4);
      end
      if (arch_count >= num_pkts) begin
        if (good_count > 0 && bad_count > 0 && fence_count > 0) begin
          $display("Simulation passed");
          $finish;
        end else begin
          $display("run ended without a good, a bad and a fence.i case");
          $display("Simulation failed");
          $fatal(1);
        end
      end
    end
  end

endmodule

/* hw/fetch_pc_ctrl.sv */
`timescale 1ns/1ps

module fetch_pc_ctrl
  import riscv_isa_pkg::*;
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            hit_i,
  input  logic [ilen-1:0] inst_i,
  input  logic            refill_busy_i,
  output logic [xlen-1:0] lookup_pc_o,
  output logic            invalidate_o,
  output logic            valid_o,
  input  logic            ready_i,
  output fetch_pkt_t      pkt_o,
  input  commit_t         commit_i,
  output spec_t           spec_o
);

  typedef enum logic [1:0] {
    st_run,
    st_load,
    st_fence,
    st_branch
  } stall_e;

  stall_e          stall_q;
  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] pc_step;
  logic            spec_q;
  logic            good_q;
  logic            bad_q;
  logic            btb_valid_q;
  logic [xlen-1:0] btb_q;
  logic [xlen-1:0] pred_q;
  logic [xlen-1:0] spec_pc_q;

  opcode_e         op;
  logic            is_branch;
  logic            is_load;
  logic            is_store;
  logic            is_fence;
  logic            accept;
  logic            predict;
  logic            resolve;
  logic [xlen-1:0] true_next;

  // predecode
  always_comb begin
    case (inst_i[op_w-1:0])
      op_jal:      op = op_jal;
      op_jalr:     op = op_jalr;
      op_branch:   op = op_branch;
      op_system:   op = op_system;
      op_load:     op = op_load;
      op_store:    op = op_store;
      op_misc_mem: op = op_misc_mem;
      default:     op = op_other;
    endcase
  end

  assign is_branch = (op == op_jal) || (op == op_jalr) || (op == op_branch) ||
                     (op == op_system);
  assign is_load   = (op == op_load);
  assign is_store  = (op == op_store);
  assign is_fence  = (op == op_misc_mem) && (inst_i == inst_fence_i);

  // memory ops wait until the open prediction is resolved
  assign valid_o = hit_i && !refill_busy_i && (stall_q == st_run) && !bad_q &&
                   !(spec_q && (is_load || is_store));
  assign accept  = valid_o && ready_i;
  assign predict = accept && is_branch && btb_valid_q && !spec_q;

  assign pc_step      = pc_q + xlen'(4);
  assign lookup_pc_o  = pc_q;
  assign invalidate_o = accept && is_fence;
  assign pkt_o        = '{pc: pc_q, inst: inst_i};

  // older plain retires may still arrive, match on the branch pc
  assign resolve   = spec_q && (commit_i.redirect ||
                     (commit_i.retire && commit_i.retire_pc == spec_pc_q));
  assign true_next = commit_i.redirect ? commit_i.redirect_target
                                       : commit_i.retire_pc + xlen'(4);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= pc_reset;
      stall_q     <= st_run;
      spec_q      <= 1'b0;
      good_q      <= 1'b0;
      bad_q       <= 1'b0;
      btb_valid_q <= 1'b0;
    end else begin
      good_q <= 1'b0;
      bad_q  <= 1'b0;
      if (commit_i.redirect) begin
        btb_valid_q <= 1'b1;
      end
      if (accept) begin
        if (predict) begin
          pc_q   <= btb_q;
          spec_q <= 1'b1;
        end else if (is_branch) begin
          stall_q <= st_branch;
        end else if (is_load) begin
          stall_q <= st_load;
        end else if (is_fence) begin
          stall_q <= st_fence;
        end else begin
          pc_q <= pc_step;
        end
      end
      // stalls release only once no prediction is open
      if (!spec_q) begin
        case (stall_q)
          st_load: begin
            if (commit_i.load_retire) begin
              stall_q <= st_run;
              pc_q    <= pc_step;
            end
          end
          st_fence: begin
            if (commit_i.retire && commit_i.retire_pc == pc_q) begin
              stall_q <= st_run;
              pc_q    <= pc_step;
            end
          end
          st_branch: begin
            if (commit_i.redirect) begin
              stall_q <= st_run;
              pc_q    <= commit_i.redirect_target;
            end else if (commit_i.retire && commit_i.retire_pc == pc_q) begin
              stall_q <= st_run;
              pc_q    <= pc_step;
            end
          end
          default: ;
        endcase
      end
      // wrong path is dropped, any stall it opened goes with it
      if (resolve) begin
        spec_q <= 1'b0;
        if (true_next == pred_q) begin
          good_q <= 1'b1;
        end else begin
          bad_q   <= 1'b1;
          pc_q    <= true_next;
          stall_q <= st_run;
        end
      end
    end
  end

  // target buffer holds the last redirect
  always_ff @(posedge clk) begin
    if (commit_i.redirect) begin
      btb_q <= commit_i.redirect_target;
    end
    if (predict) begin
      pred_q    <= btb_q;
      spec_pc_q <= pc_q;
    end
  end

  assign spec_o = '{active: spec_q, good: good_q, bad: bad_q};

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

  import riscv_isa_pkg::*;

  // L1I geometry, fixed by the two-beat refill
  localparam int line_words = 2;
  localparam int num_lines = 4;
  localparam int idx_w = 2;
  localparam int off_w = 1;
  localparam int byte_w = 2;
  localparam int tag_w = xlen - idx_w - off_w - byte_w;

  // one word read, valid is a single-cycle strobe
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic            valid;
  } mem_req_t;

  // read data, valid is a single-cycle strobe
  typedef struct packed {
    logic [xlen-1:0] data;
    logic            valid;
  } mem_rsp_t;

  // whole-line write from refill into the cache
  typedef struct packed {
    logic [idx_w-1:0]                index;
    logic [tag_w-1:0]                tag;
    logic [line_words-1:0][xlen-1:0] words;
    logic                            valid;
  } line_fill_t;

  // back-end reports, every flag is a one-cycle strobe
  typedef struct packed {
    logic            redirect;
    logic [xlen-1:0] redirect_target;
    logic            retire;
    logic [xlen-1:0] retire_pc;
    logic            load_retire;
  } commit_t;

  // packet handed to decode
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [ilen-1:0] inst;
  } fetch_pkt_t;

  // active is a level, good and bad are pulses
  typedef struct packed {
    logic active;
    logic good;
    logic bad;
  } spec_t;

endpackage

/* hw/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top
  import riscv_isa_pkg::*;
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output mem_req_t   mem_req_o,
  input  mem_rsp_t   mem_rsp_i,
  input  commit_t    commit_i,
  input  logic       ready_i,
  output logic       valid_o,
  output fetch_pkt_t pkt_o,
  output spec_t      spec_o
);

  logic [xlen-1:0] lookup_pc;
  logic [ilen-1:0] inst;
  logic            hit;
  logic            miss;
  logic            invalidate;
  logic            refill_busy;
  line_fill_t      fill;

  // a lookup that misses starts a refill of that line
  assign miss = !hit;

  icache_refill u_refill (
    .clk       (clk),
    .rst       (rst),
    .miss_i    (miss),
    .miss_pc_i (lookup_pc),
    .mem_req_o (mem_req_o),
    .mem_rsp_i (mem_rsp_i),
    .fill_o    (fill),
    .busy_o    (refill_busy)
  );

  icache_l1i u_l1i (
    .clk          (clk),
    .rst          (rst),
    .lookup_pc_i  (lookup_pc),
    .hit_o        (hit),
    .inst_o       (inst),
    .fill_i       (fill),
    .invalidate_i (invalidate)
  );

  fetch_pc_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .hit_i         (hit),
    .inst_i        (inst),
    .refill_busy_i (refill_busy),
    .lookup_pc_o   (lookup_pc),
    .invalidate_o  (invalidate),
    .valid_o       (valid_o),
    .ready_i       (ready_i),
    .pkt_o         (pkt_o),
    .commit_i      (commit_i),
    .spec_o        (spec_o)
  );

endmodule

/* hw/icache_l1i.sv */
`timescale 1ns/1ps

module icache_l1i
  import riscv_isa_pkg::*;
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic [xlen-1:0] lookup_pc_i,
  output logic            hit_o,
  output logic [ilen-1:0] inst_o,
  input  line_fill_t      fill_i,
  input  logic            invalidate_i
);

  logic [tag_w-1:0]                tag_q  [num_lines];
  logic [line_words-1:0][xlen-1:0] data_q [num_lines];
  logic [num_lines-1:0]            valid_q;

  logic [tag_w-1:0] lookup_tag;
  logic [idx_w-1:0] lookup_idx;
  logic [off_w-1:0] lookup_off;

  // address split: tag | index | word offset | byte
  assign lookup_tag = lookup_pc_i[xlen-1:idx_w+off_w+byte_w];
  assign lookup_idx = lookup_pc_i[idx_w+off_w+byte_w-1:off_w+byte_w];
  assign lookup_off = lookup_pc_i[off_w+byte_w-1:byte_w];

  assign hit_o  = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign inst_o = data_q[lookup_idx][lookup_off];

  // fill comes after the flush so a same-cycle fill keeps its line
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      if (invalidate_i) begin
        valid_q <= '0;
      end
      if (fill_i.valid) begin
        valid_q[fill_i.index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_i.valid) begin
      tag_q[fill_i.index]  <= fill_i.tag;
      data_q[fill_i.index] <= fill_i.words;
    end
  end

endmodule

/* hw/icache_refill.sv */
`timescale 1ns/1ps

module icache_refill
  import riscv_isa_pkg::*;
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            miss_i,
  input  logic [xlen-1:0] miss_pc_i,
  output mem_req_t        mem_req_o,
  input  mem_rsp_t        mem_rsp_i,
  output line_fill_t      fill_o,
  output logic            busy_o
);

  typedef enum logic [2:0] {
    rf_idle,
    rf_req0,
    rf_wait0,
    rf_req1,
    rf_wait1,
    rf_write
  } refill_state_e;

  refill_state_e state_q;
  refill_state_e state_d;

  logic [xlen-1:0]                 base_q;
  logic [line_words-1:0][xlen-1:0] words_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      rf_idle: begin
        if (miss_i) begin
          state_d = rf_req0;
        end
      end
      rf_req0: state_d = rf_wait0;
      rf_wait0: begin
        if (mem_rsp_i.valid) begin
          state_d = rf_req1;
        end
      end
      rf_req1: state_d = rf_wait1;
      rf_wait1: begin
        if (mem_rsp_i.valid) begin
          state_d = rf_write;
        end
      end
      rf_write: state_d = rf_idle;
      default: state_d = rf_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= rf_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // line base latched on the miss, words collected per beat
  always_ff @(posedge clk) begin
    if (state_q == rf_idle && miss_i) begin
      base_q <= {miss_pc_i[xlen-1:off_w+byte_w], {(off_w + byte_w){1'b0}}};
    end
    if (state_q == rf_wait0 && mem_rsp_i.valid) begin
      words_q[0] <= mem_rsp_i.data;
    end
    if (state_q == rf_wait1 && mem_rsp_i.valid) begin
      words_q[1] <= mem_rsp_i.data;
    end
  end

  assign mem_req_o.addr  = (state_q == rf_req1) ? base_q + xlen'(4) : base_q;
  assign mem_req_o.valid = (state_q == rf_req0) || (state_q == rf_req1);

  assign fill_o.index = base_q[idx_w+off_w+byte_w-1:off_w+byte_w];
  assign fill_o.tag   = base_q[xlen-1:idx_w+off_w+byte_w];
  assign fill_o.words = words_q;
  assign fill_o.valid = (state_q == rf_write);

  assign busy_o = (state_q != rf_idle);

endmodule

/* hw/riscv_isa_pkg.sv */
package riscv_isa_pkg;

  // register and address width
  localparam int xlen = 32;

  // instruction width
  localparam int ilen = 32;

  // base opcode field, inst[6:0]
  localparam int op_w = 7;

  // predecode classes, values are the RV32I base opcodes
  // op_other stands for every opcode fetch does not care about
  typedef enum logic [op_w-1:0] {
    op_load     = 7'b0000011,
    op_misc_mem = 7'b0001111,
    op_store    = 7'b0100011,
    op_other    = 7'b0110011,
    op_branch   = 7'b1100011,
    op_jalr     = 7'b1100111,
    op_jal      = 7'b1101111,
    op_system   = 7'b1110011
  } opcode_e;

  // fence.i with rd = rs1 = 0, imm = 0
  localparam logic [ilen-1:0] inst_fence_i = 32'h0000_100f;

  // first fetch address after reset
  localparam logic [xlen-1:0] pc_reset = 32'h0000_0000;

endpackage

/* sources.f */
hw/riscv_isa_pkg.sv
hw/fetch_pkg.sv
hw/icache_refill.sv
hw/icache_l1i.sv
hw/fetch_pc_ctrl.sv
hw/fetch_top.sv
dv/fetch_checker.sv
dv/tb_fetch.sv
